// File: source/videoTypes.sv
`default_nettype none

package videoTypes;

	// Screen coordinate width shared with the top level's posBits
	localparam int posBits = 10;

	typedef logic [posBits - 1:0] pixelCoord;

	// 4 bits each of red, green, blue
	typedef logic [11:0] rgbColor;

	////////////////////
	// Palette

	localparam rgbColor backgroundRgb = 12'h333;
	localparam rgbColor whiteUpRgb = 12'hFFF;
	localparam rgbColor whiteDownRgb = 12'h9CF;
	localparam rgbColor blackUpRgb = 12'h000;
	localparam rgbColor blackDownRgb = 12'h008;

endpackage

`default_nettype wire

// File: source/pianoTypes.sv
`default_nettype none

package pianoTypes;

	// Key width, height and gap
	localparam int dimBits = 10;

	typedef logic [dimBits - 1:0] keyDim;

	// Colour code handed from the renderer to the palette
	typedef logic [2:0] keyColor;

	localparam keyColor colorEmpty = 3'd0;
	localparam keyColor colorWhiteUp = 3'd1;
	localparam keyColor colorWhiteDown = 3'd2;
	localparam keyColor colorBlackUp = 3'd3;
	localparam keyColor colorBlackDown = 3'd4;

	////////////////////
	// Keys per octave

	localparam int whiteKeys = 7;
	localparam int blackKeys = 5;

	// Position of each key inside a 12-bit octave of the pressed vector
	localparam int whiteNoteBit [whiteKeys] = '{0, 2, 4, 5, 7, 9, 11};
	localparam int blackNoteBit [blackKeys] = '{1, 3, 6, 8, 10};

endpackage

`default_nettype wire

// File: source/rasterTiming.sv
`timescale 1ns/100ps
`default_nettype none

module rasterTiming #(
	parameter int posBits = 10,
	parameter int hActive = 640,
	parameter int hTotal = 800,
	parameter int hSyncStart = 656,
	parameter int hSyncEnd = 752,
	parameter int vActive = 480,
	parameter int vTotal = 525,
	parameter int vSyncStart = 490,
	parameter int vSyncEnd = 492
) (
	input logic clk,
	input logic reset,
	output videoTypes::pixelCoord evalX,
	output videoTypes::pixelCoord evalY,
	output logic rawActive,
	output logic rawHsync,
	output logic rawVsync
);

	logic lineEnd;
	logic frameEnd;

	assign lineEnd = (evalX == posBits'(hTotal - 1));
	assign frameEnd = (evalY == posBits'(vTotal - 1));

	////////////////////
	// Scan counters

	always_ff @(posedge clk) begin
		if (reset) begin
			evalX <= '0;
			evalY <= '0;
		end else if (lineEnd) begin
			evalX <= '0;
			if (frameEnd) begin
				evalY <= '0;
			end else begin
				evalY <= evalY + 1'b1;
			end
		end else begin
			evalX <= evalX + 1'b1;
		end
	end

	////////////////////
	// Window decode

	// Visible area
	assign rawActive = (evalX < posBits'(hActive)) && (evalY < posBits'(vActive));

	// Sync pulses are high inside their window
	assign rawHsync = (evalX >= posBits'(hSyncStart)) && (evalX < posBits'(hSyncEnd));
	assign rawVsync = (evalY >= posBits'(vSyncStart)) && (evalY < posBits'(vSyncEnd));

endmodule

`default_nettype wire

// File: source/rectHit.sv
`timescale 1ns/100ps
`default_nettype none

module rectHit (
	input pianoTypes::keyDim width,
	input pianoTypes::keyDim height,
	input videoTypes::pixelCoord centerX,
	input videoTypes::pixelCoord centerY,
	input videoTypes::pixelCoord evalX,
	input videoTypes::pixelCoord evalY,
	output logic hit
);
	import videoTypes::*;

	pixelCoord left;
	pixelCoord top;
	pixelCoord right;
	pixelCoord bottom;

	// Edges from centre and half size
	assign left = centerX - pixelCoord'(width >> 1);
	assign top = centerY - pixelCoord'(height >> 1);
	assign right = left + pixelCoord'(width);
	assign bottom = top + pixelCoord'(height);

	// Right and bottom edges are exclusive
	assign hit = (evalX >= left) && (evalX < right) && (evalY >= top) && (evalY < bottom);

endmodule

`default_nettype wire

// File: source/pianoKeys.sv
`timescale 1ns/100ps
`default_nettype none

module pianoKeys #(
	parameter int posBits = 10,
	parameter int dimBits = 10,
	parameter int octaves = 2
) (
	input logic clk,
	input logic reset,
	input pianoTypes::keyDim keyWidth,
	input pianoTypes::keyDim keyHeight,
	input pianoTypes::keyDim keySpace,
	input videoTypes::pixelCoord posX,
	input videoTypes::pixelCoord posY,
	input videoTypes::pixelCoord evalX,
	input videoTypes::pixelCoord evalY,
	input logic [12 * octaves - 1:0] pressed,
	output pianoTypes::keyColor code
);
	import videoTypes::*;
	import pianoTypes::*;

	// Black key centres in pitches from the octave start and eighths of a key width
	localparam int blackPitchMul [blackKeys] = '{1, 2, 4, 5, 6};
	localparam int blackShift [blackKeys] = '{-1, 1, -1, 0, 1};

	keyDim pitch;
	keyDim eighth;
	keyDim blackWidth;
	keyDim blackHeight;
	keyDim maskWidth;
	keyDim maskHeight;
	pixelCoord whiteCenterY;
	pixelCoord blackCenterY;

	logic [whiteKeys * octaves - 1:0] whiteHit;
	logic [whiteKeys * octaves - 1:0] whiteDown;
	logic [blackKeys * octaves - 1:0] blackHit;
	logic [blackKeys * octaves - 1:0] blackDown;
	logic [blackKeys * octaves - 1:0] maskHit;
	keyColor nextCode;

	////////////////////
	// Key geometry

	assign pitch = dimBits'(keyWidth + keySpace);
	assign eighth = keyWidth >> 3;
	assign blackWidth = dimBits'(3 * eighth);
	assign blackHeight = dimBits'(7 * (keyHeight >> 4));

	// Gap band around each black key
	assign maskWidth = dimBits'(blackWidth + 2 * keySpace);
	assign maskHeight = dimBits'(blackHeight + 2 * keySpace);

	assign whiteCenterY = posBits'(posY + (keyHeight >> 1));
	// Even heights sit one row higher
	assign blackCenterY = posBits'(posY + keyHeight - (blackHeight >> 1)
		- (keyHeight[0] ? 0 : 1));

	////////////////////
	// Hit tests

	for (genvar o = 0; o < octaves; o++) begin : octaveGen
		pixelCoord octaveBase;

		assign octaveBase = posBits'(posX + whiteKeys * o * pitch);

		for (genvar n = 0; n < whiteKeys; n++) begin : whiteGen
			pixelCoord centerX;

			assign centerX = posBits'(octaveBase + (keyWidth >> 1) + n * pitch);
			assign whiteDown[o * whiteKeys + n] = pressed[12 * o + whiteNoteBit[n]];

			rectHit whiteRect (
				.width(keyWidth),
				.height(keyHeight),
				.centerX(centerX),
				.centerY(whiteCenterY),
				.evalX(evalX),
				.evalY(evalY),
				.hit(whiteHit[o * whiteKeys + n])
			);
		end

		for (genvar b = 0; b < blackKeys; b++) begin : blackGen
			pixelCoord centerX;

			assign centerX = posBits'(octaveBase + blackPitchMul[b] * pitch
				+ blackShift[b] * eighth);
			assign blackDown[o * blackKeys + b] = pressed[12 * o + blackNoteBit[b]];

			// Mask and key share a centre
			rectHit maskRect (
				.width(maskWidth),
				.height(maskHeight),
				.centerX(centerX),
				.centerY(blackCenterY),
				.evalX(evalX),
				.evalY(evalY),
				.hit(maskHit[o * blackKeys + b])
			);

			rectHit blackRect (
				.width(blackWidth),
				.height(blackHeight),
				.centerX(centerX),
				.centerY(blackCenterY),
				.evalX(evalX),
				.evalY(evalY),
				.hit(blackHit[o * blackKeys + b])
			);
		end
	end

	////////////////////
	// Layer priority

	// Scans run downwards so the lowest octave is applied last and wins
	always_comb begin
		nextCode = colorEmpty;
		if (|blackHit) begin
			for (int i = blackKeys * octaves - 1; i >= 0; i--) begin
				if (blackHit[i]) begin
					nextCode = blackDown[i] ? colorBlackDown : colorBlackUp;
				end
			end
		end else if (!(|maskHit)) begin
			for (int i = whiteKeys * octaves - 1; i >= 0; i--) begin
				if (whiteHit[i]) begin
					nextCode = whiteDown[i] ? colorWhiteDown : colorWhiteUp;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			code <= colorEmpty;
		end else begin
			code <= nextCode;
		end
	end

endmodule

`default_nettype wire

// File: source/keyPalette.sv
`timescale 1ns/100ps
`default_nettype none

module keyPalette (
	input logic clk,
	input logic reset,
	input pianoTypes::keyColor code,
	input logic rawActive,
	input logic rawHsync,
	input logic rawVsync,
	output videoTypes::rgbColor rgb,
	output logic active,
	output logic hsync,
	output logic vsync
);
	import videoTypes::*;
	import pianoTypes::*;

	rgbColor paletteRgb;
	logic activeStage;
	logic hsyncStage;
	logic vsyncStage;

	always_comb begin
		case (code)
			colorWhiteUp: paletteRgb = whiteUpRgb;
			colorWhiteDown: paletteRgb = whiteDownRgb;
			colorBlackUp: paletteRgb = blackUpRgb;
			colorBlackDown: paletteRgb = blackDownRgb;
			default: paletteRgb = backgroundRgb;
		endcase
	end

	// First stage lines up with the renderer register, second with rgb
	always_ff @(posedge clk) begin
		if (reset) begin
			activeStage <= 1'b0;
			hsyncStage <= 1'b0;
			vsyncStage <= 1'b0;
			active <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			rgb <= '0;
		end else begin
			activeStage <= rawActive;
			hsyncStage <= rawHsync;
			vsyncStage <= rawVsync;
			active <= activeStage;
			hsync <= hsyncStage;
			vsync <= vsyncStage;
			rgb <= activeStage ? paletteRgb : '0;
		end
	end

endmodule

`default_nettype wire

// File: source/pianoDisplay.sv
`timescale 1ns/100ps
`default_nettype none

module pianoDisplay #(
	parameter int posBits = 10,
	parameter int dimBits = 10,
	parameter int octaves = 2,
	parameter int hActive = 640,
	parameter int hTotal = 800,
	parameter int hSyncStart = 656,
	parameter int hSyncEnd = 752,
	parameter int vActive = 480,
	parameter int vTotal = 525,
	parameter int vSyncStart = 490,
	parameter int vSyncEnd = 492
) (
	input logic clk,
	input logic reset,
	input pianoTypes::keyDim keyWidth,
	input pianoTypes::keyDim keyHeight,
	input pianoTypes::keyDim keySpace,
	input videoTypes::pixelCoord posX,
	input videoTypes::pixelCoord posY,
	input logic [12 * octaves - 1:0] pressed,
	output videoTypes::rgbColor rgb,
	output logic hsync,
	output logic vsync,
	output logic active
);
	import videoTypes::*;
	import pianoTypes::*;

	pixelCoord evalX;
	pixelCoord evalY;
	logic rawActive;
	logic rawHsync;
	logic rawVsync;
	keyColor code;

	rasterTiming #(
		.posBits(posBits),
		.hActive(hActive),
		.hTotal(hTotal),
		.hSyncStart(hSyncStart),
		.hSyncEnd(hSyncEnd),
		.vActive(vActive),
		.vTotal(vTotal),
		.vSyncStart(vSyncStart),
		.vSyncEnd(vSyncEnd)
	) timing_i (
		.clk(clk),
		.reset(reset),
		.evalX(evalX),
		.evalY(evalY),
		.rawActive(rawActive),
		.rawHsync(rawHsync),
		.rawVsync(rawVsync)
	);

	pianoKeys #(
		.posBits(posBits),
		.dimBits(dimBits),
		.octaves(octaves)
	) keys_i (
		.clk(clk),
		.reset(reset),
		.keyWidth(keyWidth),
		.keyHeight(keyHeight),
		.keySpace(keySpace),
		.posX(posX),
		.posY(posY),
		.evalX(evalX),
		.evalY(evalY),
		.pressed(pressed),
		.code(code)
	);

	keyPalette palette_i (
		.clk(clk),
		.reset(reset),
		.code(code),
		.rawActive(rawActive),
		.rawHsync(rawHsync),
		.rawVsync(rawVsync),
		.rgb(rgb),
		.active(active),
		.hsync(hsync),
		.vsync(vsync)
	);

endmodule

`default_nettype wire

// File: verification/pianoChecker.sv
`timescale 1ns/100ps
`default_nettype none

module pianoChecker #(
	parameter int octaves = 2,
	parameter int hActive = 96,
	parameter int hTotal = 112,
	parameter int hSyncStart = 100,
	parameter int hSyncEnd = 106,
	parameter int vActive = 40,
	parameter int vTotal = 46,
	parameter int vSyncStart = 42,
	parameter int vSyncEnd = 44
) (
	input logic clk,
	input logic reset,
	input pianoTypes::keyDim keyWidth,
	input pianoTypes::keyDim keyHeight,
	input pianoTypes::keyDim keySpace,
	input videoTypes::pixelCoord posX,
	input videoTypes::pixelCoord posY,
	input logic [12 * octaves - 1:0] pressed,
	input videoTypes::rgbColor rgb,
	input logic hsync,
	input logic vsync,
	input logic active,
	output int errorCount,
	output int checkCount,
	output logic [4:0] codesSeen
);
	import videoTypes::*;
	import pianoTypes::*;

	int scanX = 0;
	int scanY = 0;
	int pixX1 = 0;
	int pixY1 = 0;
	int pixX2 = 0;
	int pixY2 = 0;
	logic [12 * octaves - 1:0] keys1 = '0;
	logic [12 * octaves - 1:0] keys2 = '0;
	logic valid1 = 1'b0;
	logic valid2 = 1'b0;
	int errors = 0;
	int checks = 0;
	logic [4:0] seen = '0;

	assign errorCount = errors;
	assign checkCount = checks;
	assign codesSeen = seen;

	////////////////////
	// Reference model

	function automatic logic inRect(input int x, input int y, input int cx, input int cy,
		input int w, input int h);
		int left;
		int top;
		left = cx - w / 2;
		top = cy - h / 2;
		return (x >= left) && (x < left + w) && (y >= top) && (y < top + h);
	endfunction

	function automatic keyColor expectedCode(input int x, input int y,
		input logic [12 * octaves - 1:0] keys);
		int kw;
		int kh;
		int ks;
		int pitch;
		int eighth;
		int bw;
		int bh;
		int whiteY;
		int blackY;
		int cx;
		int blackOffset [5];
		int blackBits [5];
		int whiteBits [7];
		kw = int'(keyWidth);
		kh = int'(keyHeight);
		ks = int'(keySpace);
		pitch = kw + ks;
		eighth = kw / 8;
		bw = 3 * eighth;
		bh = 7 * (kh / 16);
		whiteY = int'(posY) + kh / 2;
		blackY = int'(posY) + kh - bh / 2 - ((kh % 2 == 0) ? 1 : 0);
		blackOffset = '{pitch - eighth, 2 * pitch + eighth, 4 * pitch - eighth,
			5 * pitch, 6 * pitch + eighth};
		blackBits = '{1, 3, 6, 8, 10};
		whiteBits = '{0, 2, 4, 5, 7, 9, 11};

		// Black keys first and the lowest octave wins
		for (int o = 0; o < octaves; o++) begin
			for (int b = 0; b < 5; b++) begin
				cx = int'(posX) + 7 * o * pitch + blackOffset[b];
				if (inRect(x, y, cx, blackY, bw, bh)) begin
					return keys[12 * o + blackBits[b]] ? colorBlackDown : colorBlackUp;
				end
			end
		end
		// Mask band is bigger by the gap on every side
		for (int o = 0; o < octaves; o++) begin
			for (int b = 0; b < 5; b++) begin
				cx = int'(posX) + 7 * o * pitch + blackOffset[b];
				if (inRect(x, y, cx, blackY, bw + 2 * ks, bh + 2 * ks)) begin
					return colorEmpty;
				end
			end
		end
		for (int o = 0; o < octaves; o++) begin
			for (int n = 0; n < 7; n++) begin
				cx = int'(posX) + kw / 2 + (7 * o + n) * pitch;
				if (inRect(x, y, cx, whiteY, kw, kh)) begin
					return keys[12 * o + whiteBits[n]] ? colorWhiteDown : colorWhiteUp;
				end
			end
		end
		return colorEmpty;
	endfunction

	function automatic rgbColor expectedRgb(input keyColor code);
		case (code)
			colorWhiteUp: return whiteUpRgb;
			colorWhiteDown: return whiteDownRgb;
			colorBlackUp: return blackUpRgb;
			colorBlackDown: return blackDownRgb;
			default: return backgroundRgb;
		endcase
	endfunction

	task automatic compareValue(input string name, input logic [11:0] expected,
		input logic [11:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s expected %0h, actual %0h", $time, name,
				expected, actual);
			errors++;
		end
	endtask

	////////////////////
	// Raster tracking and compare

	// Outputs trail the scan counters by two stages
	always @(posedge clk) begin
		if (reset) begin
			scanX <= 0;
			scanY <= 0;
			valid1 <= 1'b0;
			valid2 <= 1'b0;
		end else begin
			if (scanX == hTotal - 1) begin
				scanX <= 0;
				scanY <= (scanY == vTotal - 1) ? 0 : scanY + 1;
			end else begin
				scanX <= scanX + 1;
			end
			pixX1 <= scanX;
			pixY1 <= scanY;
			keys1 <= pressed;
			valid1 <= 1'b1;
			pixX2 <= pixX1;
			pixY2 <= pixY1;
			keys2 <= keys1;
			valid2 <= valid1;
		end
	end

	always @(negedge clk) begin : compareBlock
		logic expActive;
		logic expHsync;
		logic expVsync;
		keyColor code;
		rgbColor expRgb;
		expActive = 1'b0;
		expHsync = 1'b0;
		expVsync = 1'b0;
		expRgb = '0;
		if (valid2) begin
			expActive = (pixX2 < hActive) && (pixY2 < vActive);
			expHsync = (pixX2 >= hSyncStart) && (pixX2 < hSyncEnd);
			expVsync = (pixY2 >= vSyncStart) && (pixY2 < vSyncEnd);
			if (expActive) begin
				code = expectedCode(pixX2, pixY2, keys2);
				expRgb = expectedRgb(code);
				seen[code] = 1'b1;
			end
		end
		checks++;
		compareValue("rgb", expRgb, rgb);
		compareValue("active", 12'(expActive), 12'(active));
		compareValue("hsync", 12'(expHsync), 12'(hsync));
		compareValue("vsync", 12'(expVsync), 12'(vsync));
	end

endmodule

`default_nettype wire

// File: verification/pianoDisplayTb.sv
`timescale 1ns/100ps
`default_nettype none

module pianoDisplayTb;
	import videoTypes::*;
	import pianoTypes::*;

	localparam int hActive = 96;
	localparam int hTotal = 112;
	localparam int hSyncStart = 100;
	localparam int hSyncEnd = 106;
	localparam int vActive = 40;
	localparam int vTotal = 46;
	localparam int vSyncStart = 42;
	localparam int vSyncEnd = 44;
	localparam int octaves = 2;
	localparam int frames = 4;
	localparam int frameCycles = hTotal * vTotal;
	localparam int timeoutCycles = frames * frameCycles + 20;

	logic clk = 1'b0;
	logic reset;
	keyDim keyWidth;
	keyDim keyHeight;
	keyDim keySpace;
	pixelCoord posX;
	pixelCoord posY;
	logic [12 * octaves - 1:0] pressed;
	rgbColor rgb;
	logic hsync;
	logic vsync;
	logic active;

	logic [31:0] lfsr;
	int cycleCount = 0;
	int otherErrors = 0;
	int errorCount;
	int checkCount;
	logic [4:0] codesSeen;

	always #5 clk = ~clk;

	function automatic logic [31:0] stepLfsr(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 32'h80200003;
		end
		return next;
	endfunction

	// One LFSR step per key bit
	task automatic drawPressed();
		for (int i = 0; i < 12 * octaves; i++) begin
			pressed[i] = lfsr[0];
			lfsr = stepLfsr(lfsr);
		end
	endtask

	task automatic setGeometry(input int width);
		keyWidth = keyDim'(width);
		keyHeight = keyDim'(32);
		keySpace = keyDim'(1);
		posX = pixelCoord'(2);
		posY = pixelCoord'(4);
	endtask

	task automatic waitVsyncHigh();
		do @(negedge clk); while (vsync !== 1'b1);
	endtask

	task automatic waitVsyncLow();
		do @(negedge clk); while (vsync !== 1'b0);
	endtask

	////////////////////
	// Stimulus

	initial begin
		reset = 1'b1;
		lfsr = 32'd71414;
		setGeometry(6);
		drawPressed();
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;

		// New keys during each vertical sync, shown in the next frame
		for (int f = 0; f < frames; f++) begin
			waitVsyncHigh();
			if (f < frames - 1) begin
				@(posedge clk);
				#1;
				drawPressed();
				// Wider keys so the black keys get a width
				if (f >= 1) begin
					setGeometry(8);
				end
				waitVsyncLow();
			end
		end

		for (int c = 0; c < 5; c++) begin
			if (!codesSeen[c]) begin
				$display("Colour code %0d never appeared in the active area", c);
				otherErrors++;
			end
		end
		$display("Compared %0d cycles: %0d mismatches, %0d other errors",
			checkCount, errorCount, otherErrors);
		if (errorCount == 0 && otherErrors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout after %0d cycles, the stimulus did not finish", cycleCount);
			$display("Compared %0d cycles: %0d mismatches, %0d other errors",
				checkCount, errorCount, otherErrors + 1);
			$display("Checks failed");
			$finish;
		end
	end

	pianoDisplay #(
		.posBits(10),
		.dimBits(10),
		.octaves(octaves),
		.hActive(hActive),
		.hTotal(hTotal),
		.hSyncStart(hSyncStart),
		.hSyncEnd(hSyncEnd),
		.vActive(vActive),
		.vTotal(vTotal),
		.vSyncStart(vSyncStart),
		.vSyncEnd(vSyncEnd)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.keyWidth(keyWidth),
		.keyHeight(keyHeight),
		.keySpace(keySpace),
		.posX(posX),
		.posY(posY),
		.pressed(pressed),
		.rgb(rgb),
		.hsync(hsync),
		.vsync(vsync),
		.active(active)
	);

	pianoChecker #(
		.octaves(octaves),
		.hActive(hActive),
		.hTotal(hTotal),
		.hSyncStart(hSyncStart),
		.hSyncEnd(hSyncEnd),
		.vActive(vActive),
		.vTotal(vTotal),
		.vSyncStart(vSyncStart),
		.vSyncEnd(vSyncEnd)
	) checker_i (
		.clk(clk),
		.reset(reset),
		.keyWidth(keyWidth),
		.keyHeight(keyHeight),
		.keySpace(keySpace),
		.posX(posX),
		.posY(posY),
		.pressed(pressed),
		.rgb(rgb),
		.hsync(hsync),
		.vsync(vsync),
		.active(active),
		.errorCount(errorCount),
		.checkCount(checkCount),
		.codesSeen(codesSeen)
	);

endmodule

`default_nettype wire

// File: build.f
source/videoTypes.sv
source/pianoTypes.sv
source/rasterTiming.sv
source/rectHit.sv
source/pianoKeys.sv
source/keyPalette.sv
source/pianoDisplay.sv
verification/pianoChecker.sv
verification/pianoDisplayTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the piano display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f build.f --top-module pianoDisplayTb \
	-Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^All checks passed$" sim.log; then
	exit 0
fi
exit 1
